// ==== logic/exe_pkg.sv ====
package exe_pkg;

  typedef logic [31:0] word_t;    // operands, results, address, hi/lo
  typedef logic [15:0] imm_t;     // signed load/store offset
  typedef logic [3:0]  strobe_t;  // bit k enables byte k
  typedef logic [1:0]  size_t;    // access size code

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  typedef enum logic [4:0] {
    OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
    OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
    OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
    OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
    OP_LB, OP_LH, OP_LW, OP_LWL, OP_LWR,
    OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR
  } exe_op_t;

  typedef enum logic [1:0] {
    EXC_NONE,
    EXC_OVERFLOW,
    EXC_ADEL,     // misaligned load
    EXC_ADES      // misaligned store
  } exc_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_t;

  localparam int DIV_STEPS = 32;  // one quotient bit per step
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);

  typedef logic [DIV_CNT_W-1:0] div_cnt_t;

  localparam div_cnt_t DIV_LAST = div_cnt_t'(DIV_STEPS - 1);

endpackage

// ==== logic/arith_path.sv ====
module arith_path (
  input  exe_pkg::exe_op_t op,
  input  exe_pkg::word_t   src_a,
  input  exe_pkg::word_t   src_b,
  input  exe_pkg::imm_t    imm,
  output exe_pkg::word_t   alu_result,
  output exe_pkg::word_t   mem_addr,
  output exe_pkg::strobe_t mem_wstrb,
  output exe_pkg::word_t   mem_wdata,
  output exe_pkg::size_t   mem_size,
  output exe_pkg::exc_t    exc
);

  exe_pkg::word_t   sum;
  exe_pkg::word_t   diff;
  exe_pkg::word_t   addr;
  exe_pkg::strobe_t wstrb_raw;
  exe_pkg::size_t   size_left;
  exe_pkg::size_t   size_right;
  logic [1:0]       k;          // byte offset within the word
  logic             add_ovf;
  logic             sub_ovf;
  logic             is_load;
  logic             is_store;
  logic             misaligned;

  assign sum  = src_a + src_b;
  assign diff = src_a - src_b;
  assign addr = src_a + {{16{imm[15]}}, imm};
  assign k    = addr[1:0];

  // same-sign operands giving a result of the other sign
  assign add_ovf = (src_a[31] == src_b[31]) && (sum[31] != src_a[31]);
  assign sub_ovf = (src_a[31] != src_b[31]) && (diff[31] != src_a[31]);

  assign is_load  = op inside {exe_pkg::OP_LB, exe_pkg::OP_LH, exe_pkg::OP_LW,
                               exe_pkg::OP_LWL, exe_pkg::OP_LWR};
  assign is_store = op inside {exe_pkg::OP_SB, exe_pkg::OP_SH, exe_pkg::OP_SW,
                               exe_pkg::OP_SWL, exe_pkg::OP_SWR};

  assign size_left  = (k == 2'd0) ? exe_pkg::SIZE_BYTE :
                      (k == 2'd1) ? exe_pkg::SIZE_HALF : exe_pkg::SIZE_WORD;
  assign size_right = (k == 2'd3) ? exe_pkg::SIZE_BYTE :
                      (k == 2'd2) ? exe_pkg::SIZE_HALF : exe_pkg::SIZE_WORD;

  always_comb
  begin
    case (op)
      exe_pkg::OP_LW, exe_pkg::OP_SW: misaligned = (k != 2'd0);
      exe_pkg::OP_LH, exe_pkg::OP_SH: misaligned = k[0];
      default:                        misaligned = 1'b0;  // byte and left/right never trap
    endcase
  end

  always_comb
  begin
    case (op)
      exe_pkg::OP_ADD, exe_pkg::OP_ADDU: alu_result = sum;
      exe_pkg::OP_SUB, exe_pkg::OP_SUBU: alu_result = diff;
      exe_pkg::OP_AND:  alu_result = src_a & src_b;
      exe_pkg::OP_OR:   alu_result = src_a | src_b;
      exe_pkg::OP_XOR:  alu_result = src_a ^ src_b;
      exe_pkg::OP_SLT:  alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
      exe_pkg::OP_SLTU: alu_result = {31'b0, src_a < src_b};
      default:          alu_result = (is_load || is_store) ? addr : '0;
    endcase
  end

  always_comb
  begin
    if ((op == exe_pkg::OP_ADD && add_ovf) || (op == exe_pkg::OP_SUB && sub_ovf))
      exc = exe_pkg::EXC_OVERFLOW;
    else if (misaligned && is_load)
      exc = exe_pkg::EXC_ADEL;
    else if (misaligned && is_store)
      exc = exe_pkg::EXC_ADES;
    else
      exc = exe_pkg::EXC_NONE;
  end

  always_comb
  begin
    case (op)
      exe_pkg::OP_LB, exe_pkg::OP_SB:   mem_size = exe_pkg::SIZE_BYTE;
      exe_pkg::OP_LH, exe_pkg::OP_SH:   mem_size = exe_pkg::SIZE_HALF;
      exe_pkg::OP_LW, exe_pkg::OP_SW:   mem_size = exe_pkg::SIZE_WORD;
      exe_pkg::OP_LWL, exe_pkg::OP_SWL: mem_size = size_left;
      exe_pkg::OP_LWR, exe_pkg::OP_SWR: mem_size = size_right;
      default:                          mem_size = exe_pkg::SIZE_BYTE;
    endcase
  end

  // store lane placement
  always_comb
  begin
    wstrb_raw = '0;
    mem_wdata = src_b;
    case (op)
      exe_pkg::OP_SB:
      begin
        wstrb_raw = 4'b0001 << k;
        mem_wdata = {4{src_b[7:0]}};
      end
      exe_pkg::OP_SH:
      begin
        wstrb_raw = 4'b0011 << k;
        mem_wdata = {2{src_b[15:0]}};
      end
      exe_pkg::OP_SW:  wstrb_raw = 4'b1111;
      exe_pkg::OP_SWL:
      begin
        wstrb_raw = 4'b1111 >> (2'd3 - k);     // bytes 0..k
        mem_wdata = src_b >> {2'd3 - k, 3'b000};
      end
      exe_pkg::OP_SWR:
      begin
        wstrb_raw = 4'b1111 << k;              // bytes k..3
        mem_wdata = src_b << {k, 3'b000};
      end
      default: ;
    endcase
  end

  assign mem_wstrb = (exc != exe_pkg::EXC_NONE) ? '0 : wstrb_raw;
  assign mem_addr  = addr;  // untranslated

endmodule

// ==== logic/muldiv_unit.sv ====
module muldiv_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             stage_valid,
  input  exe_pkg::exe_op_t op,
  input  exe_pkg::word_t   src_a,
  input  exe_pkg::word_t   src_b,
  input  logic             commit,
  output exe_pkg::word_t   hi,
  output exe_pkg::word_t   lo,
  output logic             muldiv_done
);

  exe_pkg::div_state_t state;
  exe_pkg::div_cnt_t   step_cnt;
  exe_pkg::word_t      quo;       // dividend shifts out, quotient shifts in
  exe_pkg::word_t      rem;
  exe_pkg::word_t      dvsr;
  exe_pkg::word_t      a_mag;
  exe_pkg::word_t      b_mag;
  exe_pkg::word_t      quo_fix;
  exe_pkg::word_t      rem_fix;
  logic                q_neg;
  logic                r_neg;
  logic                is_div;
  logic                div_signed;
  logic [32:0]         rem_shift;
  logic [32:0]         rem_trial;
  logic [63:0]         prod_s;
  logic [63:0]         prod_u;
  logic [63:0]         prod;

  // full 64-bit operands so the low 64 product bits are exact
  assign prod_s = $signed({{32{src_a[31]}}, src_a}) * $signed({{32{src_b[31]}}, src_b});
  assign prod_u = {32'b0, src_a} * {32'b0, src_b};
  assign prod   = (op == exe_pkg::OP_MULT) ? prod_s : prod_u;

  assign is_div     = stage_valid && (op == exe_pkg::OP_DIV || op == exe_pkg::OP_DIVU);
  assign div_signed = (op == exe_pkg::OP_DIV);
  assign a_mag      = (div_signed && src_a[31]) ? -src_a : src_a;
  assign b_mag      = (div_signed && src_b[31]) ? -src_b : src_b;

  assign rem_shift = {rem, quo[31]};
  assign rem_trial = rem_shift - {1'b0, dvsr};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= exe_pkg::DIV_IDLE;
      step_cnt <= '0;
    end
    else
    begin
      case (state)
        exe_pkg::DIV_IDLE:
        begin
          if (is_div)
          begin
            state    <= exe_pkg::DIV_RUN;
            step_cnt <= '0;
          end
        end
        exe_pkg::DIV_RUN:
        begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == exe_pkg::DIV_LAST)
            state <= exe_pkg::DIV_DONE;
        end
        exe_pkg::DIV_DONE:
        begin
          if (commit)
            state <= exe_pkg::DIV_IDLE;  // result leaves with the instruction
        end
        default: state <= exe_pkg::DIV_IDLE;
      endcase
    end
  end

  // restoring divider datapath
  always_ff @(posedge clk)
  begin
    if (state == exe_pkg::DIV_IDLE && is_div)
    begin
      quo   <= a_mag;
      rem   <= '0;
      dvsr  <= b_mag;
      q_neg <= div_signed && (src_a[31] ^ src_b[31]);
      r_neg <= div_signed && src_a[31];  // remainder follows dividend
    end
    else if (state == exe_pkg::DIV_RUN)
    begin
      if (!rem_trial[32])
      begin
        rem <= rem_trial[31:0];
        quo <= {quo[30:0], 1'b1};
      end
      else
      begin
        rem <= rem_shift[31:0];
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

  assign quo_fix = q_neg ? -quo : quo;
  assign rem_fix = r_neg ? -rem : rem;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi <= '0;
      lo <= '0;
    end
    else if (commit)
    begin
      case (op)
        exe_pkg::OP_MULT, exe_pkg::OP_MULTU:
        begin
          hi <= prod[63:32];
          lo <= prod[31:0];
        end
        exe_pkg::OP_DIV, exe_pkg::OP_DIVU:
        begin
          hi <= rem_fix;
          lo <= quo_fix;
        end
        exe_pkg::OP_MTHI: hi <= src_a;
        exe_pkg::OP_MTLO: lo <= src_a;
        default: ;
      endcase
    end
  end

  assign muldiv_done = !(is_div && state != exe_pkg::DIV_DONE);

endmodule

// ==== logic/exe_stage.sv ====
module exe_stage (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  exe_pkg::exe_op_t in_op,
  input  exe_pkg::word_t   in_src_a,
  input  exe_pkg::word_t   in_src_b,
  input  exe_pkg::imm_t    in_imm,
  input  logic             out_allowin,
  input  logic             muldiv_done,
  input  exe_pkg::word_t   alu_result,
  input  exe_pkg::word_t   hi,
  input  exe_pkg::word_t   lo,
  input  exe_pkg::exc_t    exc,
  output logic             in_allowin,
  output logic             stage_valid,
  output exe_pkg::exe_op_t stage_op,
  output exe_pkg::word_t   stage_src_a,
  output exe_pkg::word_t   stage_src_b,
  output exe_pkg::imm_t    stage_imm,
  output logic             commit,
  output logic             out_valid,
  output exe_pkg::word_t   out_result,
  output exe_pkg::exc_t    out_exc
);

  logic ready_go;
  logic take_in;

  // only a running divide holds the stage
  assign ready_go = muldiv_done;

  assign in_allowin = !stage_valid || (ready_go && out_allowin);
  assign take_in    = in_valid && in_allowin;
  assign out_valid  = stage_valid && ready_go;
  assign commit     = out_valid && out_allowin;

  always_ff @(posedge clk)
  begin
    if (reset)
      stage_valid <= 1'b0;
    else if (in_allowin)
      stage_valid <= in_valid;  // refill on the leaving edge
  end

  always_ff @(posedge clk)
  begin
    if (take_in)
    begin
      stage_op    <= in_op;
      stage_src_a <= in_src_a;
      stage_src_b <= in_src_b;
      stage_imm   <= in_imm;
    end
  end

  always_comb
  begin
    case (stage_op)
      exe_pkg::OP_MFHI: out_result = hi;
      exe_pkg::OP_MFLO: out_result = lo;
      default:          out_result = alu_result;
    endcase
  end

  assign out_exc = exc;

endmodule

// ==== logic/exe_unit.sv ====
module exe_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  exe_pkg::exe_op_t in_op,
  input  exe_pkg::word_t   in_src_a,
  input  exe_pkg::word_t   in_src_b,
  input  exe_pkg::imm_t    in_imm,
  input  logic             out_allowin,
  output logic             in_allowin,
  output logic             out_valid,
  output exe_pkg::word_t   out_result,
  output exe_pkg::exc_t    out_exc,
  output exe_pkg::word_t   mem_addr,
  output exe_pkg::strobe_t mem_wstrb,
  output exe_pkg::word_t   mem_wdata,
  output exe_pkg::size_t   mem_size
);

  logic             stage_valid;
  exe_pkg::exe_op_t stage_op;
  exe_pkg::word_t   stage_src_a;
  exe_pkg::word_t   stage_src_b;
  exe_pkg::imm_t    stage_imm;
  logic             commit;
  logic             muldiv_done;
  exe_pkg::word_t   alu_result;
  exe_pkg::word_t   hi;
  exe_pkg::word_t   lo;
  exe_pkg::exc_t    exc;

  exe_stage u_stage (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_src_a    (in_src_a),
    .in_src_b    (in_src_b),
    .in_imm      (in_imm),
    .out_allowin (out_allowin),
    .muldiv_done (muldiv_done),
    .alu_result  (alu_result),
    .hi          (hi),
    .lo          (lo),
    .exc         (exc),
    .in_allowin  (in_allowin),
    .stage_valid (stage_valid),
    .stage_op    (stage_op),
    .stage_src_a (stage_src_a),
    .stage_src_b (stage_src_b),
    .stage_imm   (stage_imm),
    .commit      (commit),
    .out_valid   (out_valid),
    .out_result  (out_result),
    .out_exc     (out_exc)
  );

  arith_path u_arith (
    .op         (stage_op),
    .src_a      (stage_src_a),
    .src_b      (stage_src_b),
    .imm        (stage_imm),
    .alu_result (alu_result),
    .mem_addr   (mem_addr),
    .mem_wstrb  (mem_wstrb),
    .mem_wdata  (mem_wdata),
    .mem_size   (mem_size),
    .exc        (exc)
  );

  muldiv_unit u_muldiv (
    .clk         (clk),
    .reset       (reset),
    .stage_valid (stage_valid),
    .op          (stage_op),
    .src_a       (stage_src_a),
    .src_b       (stage_src_b),
    .commit      (commit),
    .hi          (hi),
    .lo          (lo),
    .muldiv_done (muldiv_done)
  );

endmodule

// ==== testbench/exe_unit_chk.sv ====
module exe_unit_chk (
  input logic             clk,
  input logic             reset,
  input logic             in_valid,
  input logic             out_valid,
  input logic             out_allowin,
  input logic             commit,
  input exe_pkg::word_t   out_result,
  input exe_pkg::exc_t    out_exc,
  input exe_pkg::exe_op_t stage_op,
  input exe_pkg::word_t   stage_src_a,
  input exe_pkg::word_t   stage_src_b,
  input exe_pkg::imm_t    stage_imm
);

  reset_empties: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // held instruction fixes every output of the unit
  stall_holds: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_allowin |=> out_valid && $stable(out_result) && $stable(out_exc)
      && $stable(stage_op) && $stable(stage_src_a) && $stable(stage_src_b)
      && $stable(stage_imm))
    else $error("stage output changed under back-pressure");

  // a leaving instruction with nothing behind it empties the stage
  commit_drains: assert property (@(posedge clk) disable iff (reset)
    commit && !in_valid |=> !out_valid)
    else $error("out_valid still high after commit with no new instruction");

endmodule

bind exe_stage exe_unit_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .out_allowin (out_allowin),
  .commit      (commit),
  .out_result  (out_result),
  .out_exc     (out_exc),
  .stage_op    (stage_op),
  .stage_src_a (stage_src_a),
  .stage_src_b (stage_src_b),
  .stage_imm   (stage_imm)
);

// ==== testbench/exe_model.svh ====
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

typedef struct packed {
  logic             has_result;  // out_result defined for this op
  exe_pkg::word_t   result;
  exe_pkg::exc_t    exc;
  logic             is_mem;
  exe_pkg::word_t   addr;
  exe_pkg::strobe_t wstrb;
  exe_pkg::word_t   wdata;
  exe_pkg::size_t   size;
} expect_t;

function automatic logic load_op(input exe_pkg::exe_op_t op);
  return op inside {exe_pkg::OP_LB, exe_pkg::OP_LH, exe_pkg::OP_LW,
                    exe_pkg::OP_LWL, exe_pkg::OP_LWR};
endfunction

function automatic logic store_op(input exe_pkg::exe_op_t op);
  return op inside {exe_pkg::OP_SB, exe_pkg::OP_SH, exe_pkg::OP_SW,
                    exe_pkg::OP_SWL, exe_pkg::OP_SWR};
endfunction

function automatic exe_pkg::word_t effective_addr(input exe_pkg::word_t base,
                                                  input exe_pkg::imm_t imm);
  int offset;
  offset = $signed(imm);  // sign extension
  return base + offset;
endfunction

function automatic exe_pkg::word_t alu_ref(input exe_pkg::exe_op_t op,
                                           input exe_pkg::word_t a, input exe_pkg::word_t b);
  case (op)
    exe_pkg::OP_ADD, exe_pkg::OP_ADDU: return a + b;
    exe_pkg::OP_SUB, exe_pkg::OP_SUBU: return a - b;
    exe_pkg::OP_AND:  return a & b;
    exe_pkg::OP_OR:   return a | b;
    exe_pkg::OP_XOR:  return a ^ b;
    exe_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    exe_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
    default:          return '0;
  endcase
endfunction

function automatic exe_pkg::exc_t exc_ref(input exe_pkg::exe_op_t op, input exe_pkg::word_t a,
                                          input exe_pkg::word_t b, input exe_pkg::word_t addr);
  longint wide;
  wide = 0;
  if (op == exe_pkg::OP_ADD)
    wide = longint'($signed(a)) + longint'($signed(b));
  else if (op == exe_pkg::OP_SUB)
    wide = longint'($signed(a)) - longint'($signed(b));
  if (wide > longint'(32'h7fff_ffff) || wide < -longint'(32'h8000_0000))
    return exe_pkg::EXC_OVERFLOW;  // true sum outside the 32-bit signed range
  if (((op == exe_pkg::OP_LW || op == exe_pkg::OP_SW) && addr[1:0] != 2'd0) ||
      ((op == exe_pkg::OP_LH || op == exe_pkg::OP_SH) && addr[0]))
    return load_op(op) ? exe_pkg::EXC_ADEL : exe_pkg::EXC_ADES;
  return exe_pkg::EXC_NONE;
endfunction

function automatic exe_pkg::strobe_t strobe_ref(input exe_pkg::exe_op_t op, input int k);
  exe_pkg::strobe_t s;
  s = '0;
  for (int j = 0; j < 4; j++)
  begin
    case (op)
      exe_pkg::OP_SB:  s[j] = (j == k);
      exe_pkg::OP_SH:  s[j] = (j == k) || (j == k + 1);
      exe_pkg::OP_SW:  s[j] = 1'b1;
      exe_pkg::OP_SWL: s[j] = (j <= k);  // low bytes up to the offset
      exe_pkg::OP_SWR: s[j] = (j >= k);
      default:         s[j] = 1'b0;
    endcase
  end
  return s;
endfunction

function automatic exe_pkg::word_t wdata_ref(input exe_pkg::exe_op_t op,
                                             input exe_pkg::word_t b, input int k);
  case (op)
    exe_pkg::OP_SB:  return {b[7:0], b[7:0], b[7:0], b[7:0]};
    exe_pkg::OP_SH:  return {b[15:0], b[15:0]};
    exe_pkg::OP_SWL: return b >> (8 * (3 - k));
    exe_pkg::OP_SWR: return b << (8 * k);
    default:         return b;
  endcase
endfunction

function automatic exe_pkg::size_t size_ref(input exe_pkg::exe_op_t op, input int k);
  case (op)
    exe_pkg::OP_LB, exe_pkg::OP_SB:   return 2'd0;
    exe_pkg::OP_LH, exe_pkg::OP_SH:   return 2'd1;
    exe_pkg::OP_LWL, exe_pkg::OP_SWL: return (k == 0) ? 2'd0 : (k == 1) ? 2'd1 : 2'd2;
    exe_pkg::OP_LWR, exe_pkg::OP_SWR: return (k == 3) ? 2'd0 : (k == 2) ? 2'd1 : 2'd2;
    default:                          return 2'd2;
  endcase
endfunction

// new {hi, lo} after the instruction
function automatic logic [63:0] hilo_ref(input exe_pkg::exe_op_t op, input exe_pkg::word_t a,
                                         input exe_pkg::word_t b, input exe_pkg::word_t hi,
                                         input exe_pkg::word_t lo);
  longint sa;
  longint sb;
  logic [63:0] ua;
  logic [63:0] ub;
  sa = longint'($signed(a));
  sb = longint'($signed(b));
  ua = {32'b0, a};
  ub = {32'b0, b};
  case (op)
    exe_pkg::OP_MULT:  return sa * sb;
    exe_pkg::OP_MULTU: return ua * ub;
    exe_pkg::OP_DIV:   return {32'(sa % sb), 32'(sa / sb)};  // truncating division
    exe_pkg::OP_DIVU:  return {32'(ua % ub), 32'(ua / ub)};
    exe_pkg::OP_MTHI:  return {a, lo};
    exe_pkg::OP_MTLO:  return {hi, a};
    default:           return {hi, lo};
  endcase
endfunction

`endif

// ==== testbench/exe_unit_tb.sv ====
module exe_unit_tb;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_INSTR  = 2000;
  localparam int TIMEOUT    = NUM_INSTR * (exe_pkg::DIV_STEPS + 10) * CLK_PERIOD;

  `include "exe_model.svh"

  logic             clk;
  logic             reset;
  logic             in_valid;
  exe_pkg::exe_op_t in_op;
  exe_pkg::word_t   in_src_a;
  exe_pkg::word_t   in_src_b;
  exe_pkg::imm_t    in_imm;
  logic             out_allowin;
  logic             in_allowin;
  logic             out_valid;
  exe_pkg::word_t   out_result;
  exe_pkg::exc_t    out_exc;
  exe_pkg::word_t   mem_addr;
  exe_pkg::strobe_t mem_wstrb;
  exe_pkg::word_t   mem_wdata;
  exe_pkg::size_t   mem_size;

  integer           seed;
  int               accepted_cnt;
  int               retired_cnt;
  logic             expect_fast;  // non-divide accepted last edge
  logic             expect_slow;  // divide accepted last edge
  exe_pkg::word_t   model_hi;
  exe_pkg::word_t   model_lo;
  expect_t          exp_q[$];

  exe_unit UUT (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_src_a    (in_src_a),
    .in_src_b    (in_src_b),
    .in_imm      (in_imm),
    .out_allowin (out_allowin),
    .in_allowin  (in_allowin),
    .out_valid   (out_valid),
    .out_result  (out_result),
    .out_exc     (out_exc),
    .mem_addr    (mem_addr),
    .mem_wstrb   (mem_wstrb),
    .mem_wdata   (mem_wdata),
    .mem_size    (mem_size)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input exe_pkg::word_t got,
                            input exe_pkg::word_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got 0x%h expected 0x%h",
                         $time, name, got, exp));
  endtask

  task automatic check_strobe(input string name, input exe_pkg::strobe_t got,
                              input exe_pkg::strobe_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_size(input string name, input exe_pkg::size_t got,
                            input exe_pkg::size_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  task automatic check_exc(input string name, input exe_pkg::exc_t got,
                           input exe_pkg::exc_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp));
  endtask

  // expected fields of one instruction with hi/lo in program order
  function automatic expect_t predict(input exe_pkg::exe_op_t op, input exe_pkg::word_t a,
                                      input exe_pkg::word_t b, input exe_pkg::imm_t imm);
    expect_t e;
    int k;
    e.is_mem     = load_op(op) || store_op(op);
    e.addr       = effective_addr(a, imm);
    k            = e.addr[1:0];
    e.exc        = exc_ref(op, a, b, e.addr);
    e.size       = size_ref(op, k);
    e.wstrb      = (store_op(op) && e.exc == exe_pkg::EXC_NONE) ? strobe_ref(op, k) : 4'b0000;
    e.wdata      = wdata_ref(op, b, k);
    e.has_result = 1'b1;
    if (op == exe_pkg::OP_MFHI)
      e.result = model_hi;
    else if (op == exe_pkg::OP_MFLO)
      e.result = model_lo;
    else if (e.is_mem)
      e.result = e.addr;
    else
      e.result = alu_ref(op, a, b);
    if (op inside {exe_pkg::OP_MULT, exe_pkg::OP_MULTU, exe_pkg::OP_DIV, exe_pkg::OP_DIVU,
                   exe_pkg::OP_MTHI, exe_pkg::OP_MTLO})
      e.has_result = 1'b0;  // result bus undefined for hi/lo writers
    return e;
  endfunction

  task automatic next_cycle;
    @(negedge clk);
    out_allowin = ($unsigned($random(seed)) % 10) < 7;
  endtask

  task automatic draw_instr(input int idx);
    int          r;
    logic [4:0]  code;
    r = $unsigned($random(seed)) % 100;
    if (idx == 0)
      code = exe_pkg::OP_MFHI;  // hi straight out of reset
    else if (idx == 1)
      code = exe_pkg::OP_MFLO;
    else if (r < 3)
      code = ($random(seed) & 1) ? exe_pkg::OP_DIV : exe_pkg::OP_DIVU;  // rare divides
    else
    begin
      code = 5'($unsigned($random(seed)) % 25);
      if (code >= exe_pkg::OP_DIV)
        code = code + 5'd2;  // skip both divide codes
    end
    in_op    = exe_pkg::exe_op_t'(code);
    in_src_a = $random(seed);
    in_src_b = $random(seed);
    if ((in_op == exe_pkg::OP_DIV || in_op == exe_pkg::OP_DIVU) && ($random(seed) & 1))
      in_src_b = $random(seed) % 8;  // small divisors of either sign
    if (in_src_b == '0)
      in_src_b = 32'd1;
    if (($unsigned($random(seed)) % 4) != 0)
      in_imm = exe_pkg::imm_t'($random(seed) % 16);
    else
      in_imm = exe_pkg::imm_t'($random(seed));
  endtask

  // transfers are seen at the rising edge before the DUT registers update
  always @(posedge clk)
  begin
    expect_t e;
    if (!reset)
    begin
      if (expect_fast && !out_valid)
        fail_run($sformatf("out_valid did not rise one cycle after acceptance at %0t", $time));
      if (expect_slow && out_valid)
        fail_run($sformatf("divide result valid one cycle after acceptance at %0t", $time));
      expect_fast = 1'b0;
      expect_slow = 1'b0;
      if (out_valid && out_allowin)
      begin
        if (exp_q.size() == 0)
          fail_run($sformatf("DUT delivered an output with nothing pending at %0t", $time));
        e = exp_q.pop_front();
        if (e.has_result)
          check_word("out_result", out_result, e.result);
        check_exc("out_exc", out_exc, e.exc);
        check_strobe("mem_wstrb", mem_wstrb, e.wstrb);
        check_word("mem_wdata", mem_wdata, e.wdata);
        if (e.is_mem)
        begin
          check_word("mem_addr", mem_addr, e.addr);
          check_size("mem_size", mem_size, e.size);
        end
        retired_cnt++;
      end
      if (in_valid && in_allowin)
      begin
        e = predict(in_op, in_src_a, in_src_b, in_imm);
        exp_q.push_back(e);
        if (e.exc == exe_pkg::EXC_NONE)
          {model_hi, model_lo} = hilo_ref(in_op, in_src_a, in_src_b, model_hi, model_lo);
        expect_fast = !(in_op == exe_pkg::OP_DIV || in_op == exe_pkg::OP_DIVU);
        expect_slow = !expect_fast;
        accepted_cnt++;
      end
    end
  end

  initial
  begin
    seed         = 75;
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_op        = exe_pkg::OP_ADD;
    in_src_a     = '0;
    in_src_b     = '0;
    in_imm       = '0;
    out_allowin  = 1'b0;
    accepted_cnt = 0;
    retired_cnt  = 0;
    expect_fast  = 1'b0;
    expect_slow  = 1'b0;
    model_hi     = '0;
    model_lo     = '0;
    repeat (2) @(negedge clk);  // two rising edges in reset
    reset = 1'b0;
    for (int i = 0; i < NUM_INSTR; i++)
    begin
      while (($unsigned($random(seed)) % 4) == 0)
      begin
        in_valid = 1'b0;  // random gap
        next_cycle();
      end
      draw_instr(i);
      in_valid = 1'b1;
      next_cycle();
      while (accepted_cnt <= i)
        next_cycle();
    end
    in_valid = 1'b0;
    while (retired_cnt < NUM_INSTR)
      next_cycle();
    if (exp_q.size() != 0 || out_valid)
      fail_run($sformatf("output still pending at the end with %0d queued and out_valid %b",
                         exp_q.size(), out_valid));
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  // watchdog
  initial
  begin
    #(TIMEOUT);
    fail_run($sformatf("timeout after %0d of %0d instructions retired", retired_cnt, NUM_INSTR));
  end

endmodule

// ==== exe_unit.f ====
+incdir+testbench
logic/exe_pkg.sv
logic/arith_path.sv
logic/muldiv_unit.sv
logic/exe_stage.sv
logic/exe_unit.sv
testbench/exe_unit_chk.sv
testbench/exe_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f exe_unit.f \
  --top-module exe_unit_tb -o exe_unit_sim

./obj_dir/exe_unit_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failure"
exit 0
